// ==== common/tdc_pkg.sv ====
package tdc_pkg;

  // controller sequence, one state per protocol step
  typedef enum logic [3:0] {
    st_idle,
    st_config,       // register setup after soft reset
    st_shot_wait,    // shot period counter
    st_trig_write,   // start-measurement write
    st_trig_delay,   // fixed gap before start pulse
    st_start_pulse,
    st_intb_wait,    // conversion running, watch intb
    st_read_time1,
    st_read_calib1,
    st_read_calib2,
    st_calc_diff,
    st_hand_off,     // four-phase handshake with arbiter
    st_paused
  } ctrl_state_e;

  // msb of every command byte
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } spi_op_e;

  typedef logic [5:0] rom_addr_t;

  // command rom segments
  localparam rom_addr_t CFG_FIRST    = 6'd0;   // register writes, byte pairs
  localparam rom_addr_t CFG_LAST     = 6'd17;
  localparam rom_addr_t TRIG_FIRST   = 6'd18;  // start-measurement write
  localparam rom_addr_t TRIG_LAST    = 6'd19;
  localparam rom_addr_t TIME1_FIRST  = 6'd20;  // read frames, four bytes each
  localparam rom_addr_t CALIB1_FIRST = 6'd24;
  localparam rom_addr_t CALIB2_FIRST = 6'd28;

  localparam logic [15:0] ZERO_SUB = 16'd1488;  // stands in for a zero time1

endpackage

// ==== common/fifo_pkg.sv ====
package fifo_pkg;

  // one finished measurement
  typedef struct packed {
    logic        chan;        // source channel
    logic [15:0] calib_diff;  // calib2 minus calib1
    logic [15:0] time1;       // zero already substituted
  } sample_t;

  // controller to arbiter, four-phase
  typedef struct packed {
    logic    req;     // held until ack rises
    sample_t sample;  // stable while req is high
  } sample_req_t;

endpackage

// ==== tdc_ctrl/tdc_cmd_rom.sv ====
module tdc_cmd_rom
  import tdc_pkg::*;
(
  input  logic       clk,
  input  rom_addr_t  addr,
  output logic [7:0] data
);

  always_ff @(posedge clk) begin
    case (addr)
      // setup, register address then value
      6'd0:  data <= {op_write, 7'h01};  // config2
      6'd1:  data <= 8'h40;              // 10 calibration periods
      6'd2:  data <= {op_write, 7'h03};  // int_mask
      6'd3:  data <= 8'h07;              // all interrupts on
      6'd4:  data <= {op_write, 7'h04};  // coarse overflow high
      6'd5:  data <= 8'hff;
      6'd6:  data <= {op_write, 7'h05};  // coarse overflow low
      6'd7:  data <= 8'hff;
      6'd8:  data <= {op_write, 7'h06};  // clock overflow high
      6'd9:  data <= 8'h00;
      6'd10: data <= {op_write, 7'h07};  // clock overflow low
      6'd11: data <= 8'h50;
      6'd12: data <= {op_write, 7'h08};  // stop mask high
      6'd13: data <= 8'h00;
      6'd14: data <= {op_write, 7'h09};  // stop mask low
      6'd15: data <= 8'h00;
      6'd16: data <= {op_write, 7'h02};  // int_status
      6'd17: data <= 8'h1f;              // clear pending flags
      // trigger
      6'd18: data <= {op_write, 7'h00};  // config1
      6'd19: data <= 8'h03;              // mode 2, start measurement
      // reads, command then three dummy bytes
      TIME1_FIRST:  data <= {op_read, 7'h10};
      CALIB1_FIRST: data <= {op_read, 7'h1b};
      CALIB2_FIRST: data <= {op_read, 7'h1c};
      default: data <= 8'h00;            // dummies and unused space
    endcase
  end

endmodule

// ==== tdc_ctrl/tdc_ctrl.sv ====
module tdc_ctrl
  import tdc_pkg::*;
  import fifo_pkg::*;
#(
  parameter int   SHOT_PERIOD  = 1000,  // clocks between measurements
  parameter int   INTB_TIMEOUT = 100,   // give up on the chip after this
  parameter logic CHAN_ID      = 1'b0
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        soft_reset,
  input  logic        pause,
  input  logic        intb,
  input  logic        spi_busy,
  input  logic [7:0]  rx_byte,
  output logic        spi_start,
  output logic        cs_end,
  output logic [7:0]  tx_byte,
  output logic        start_pulse,
  output sample_req_t sreq,
  input  logic        ack
);

  localparam int TRIG_DELAY = 5;  // stands in for the chip trigger
  localparam int PULSE_LEN  = 3;  // start pulse width

  ctrl_state_e state_q, state_d;
  rom_addr_t   addr_q, addr_d;
  logic [31:0] cnt_q, cnt_d;      // cleared on every state change
  logic        start_q, start_d;
  logic        cs_end_q, cs_end_d;
  logic        pulse_q, pulse_d;
  logic        req_q, req_d;
  logic [15:0] time1_q, time1_d;
  logic [15:0] calib1_q, calib1_d;
  logic [15:0] calib2_q, calib2_d;
  sample_t     sample_q, sample_d;
  logic        spi_idle;          // byte finished, nothing pending
  logic        pause_ok;          // no frame open, freeze allowed

  assign spi_idle    = !spi_busy && !start_q;  // start_q covers the busy rise
  assign spi_start   = start_q;
  assign cs_end      = cs_end_q;
  assign start_pulse = pulse_q;
  assign sreq        = '{req: req_q, sample: sample_q};

  // rom is fed the next address, its byte lines up with start_q
  tdc_cmd_rom u_rom (
    .clk  (clk),
    .addr (addr_d),
    .data (tx_byte)
  );

  always_comb begin
    case (state_q)
      st_shot_wait, st_trig_delay, st_start_pulse, st_intb_wait: pause_ok = 1'b1;
      st_trig_write, st_read_time1, st_read_calib1, st_read_calib2:
        pause_ok = spi_idle && cs_end_q;  // select already released
      default: pause_ok = 1'b0;           // config and handshake run to the end
    endcase
  end

  always_comb begin
    state_d  = state_q;
    addr_d   = addr_q;
    start_d  = 1'b0;  // single-cycle pulse
    cs_end_d = cs_end_q;
    pulse_d  = pulse_q;
    req_d    = req_q;
    time1_d  = time1_q;
    calib1_d = calib1_q;
    calib2_d = calib2_q;
    sample_d = sample_q;

    case (state_q)
      st_idle: begin
        if (soft_reset) begin
          state_d  = st_config;
          addr_d   = CFG_FIRST;
          start_d  = 1'b1;
          cs_end_d = 1'b0;
        end
      end

      st_shot_wait: begin
        if (cnt_q == SHOT_PERIOD - 1) begin
          state_d  = st_trig_write;
          addr_d   = TRIG_FIRST;
          start_d  = 1'b1;
          cs_end_d = 1'b0;
        end
      end

      // every spi segment steps the rom the same way
      st_config, st_trig_write, st_read_time1, st_read_calib1, st_read_calib2: begin
        if (spi_idle) begin
          if (addr_q[1]) begin  // bytes 2 and 3 of a read carry the low word
            case (state_q)
              st_read_time1:  time1_d  = {time1_q[7:0], rx_byte};
              st_read_calib1: calib1_d = {calib1_q[7:0], rx_byte};
              st_read_calib2: calib2_d = {calib2_q[7:0], rx_byte};
              default: ;
            endcase
          end
          addr_d  = addr_q + 6'd1;
          start_d = 1'b1;
          // writes close every two bytes, reads every four
          if (state_q inside {st_config, st_trig_write})
            cs_end_d = addr_d[0];
          else
            cs_end_d = (addr_d[1:0] == 2'b11);

          if (state_q == st_config && addr_q == CFG_LAST) begin
            state_d = st_shot_wait;
            start_d = 1'b0;
          end else if (state_q == st_trig_write && addr_q == TRIG_LAST) begin
            state_d = st_trig_delay;
            start_d = 1'b0;
          end else if (addr_q == CALIB1_FIRST - 1) begin
            state_d = st_read_calib1;  // next frame follows right away
          end else if (addr_q == CALIB2_FIRST - 1) begin
            state_d = st_read_calib2;
          end else if (addr_q == CALIB2_FIRST + 3) begin
            state_d = st_calc_diff;
            start_d = 1'b0;
          end
        end
      end

      st_trig_delay: begin
        if (cnt_q == TRIG_DELAY - 1) begin
          state_d = st_start_pulse;
          pulse_d = 1'b1;
        end
      end

      st_start_pulse: begin
        if (cnt_q == PULSE_LEN - 1) begin
          state_d = st_intb_wait;
          pulse_d = 1'b0;
        end
      end

      st_intb_wait: begin
        if (!intb) begin  // conversion done
          state_d  = st_read_time1;
          addr_d   = TIME1_FIRST;
          start_d  = 1'b1;
          cs_end_d = 1'b0;
        end else if (cnt_q == INTB_TIMEOUT - 1) begin
          state_d = st_shot_wait;  // measurement lost, no sample
        end
      end

      st_calc_diff: begin
        sample_d.chan       = CHAN_ID;
        sample_d.calib_diff = calib2_q - calib1_q;
        sample_d.time1      = (time1_q == 16'd0) ? ZERO_SUB : time1_q;
        req_d               = 1'b1;
        state_d             = st_hand_off;
      end

      st_hand_off: begin
        if (req_q && ack) begin
          req_d = 1'b0;
        end else if (!req_q && !ack) begin
          state_d = st_shot_wait;  // arbiter released, next shot
        end
      end

      st_paused: begin
        if (!pause) state_d = st_shot_wait;  // restart the period
      end

      default: state_d = st_idle;
    endcase

    if (pause && pause_ok) begin
      state_d = st_paused;
      start_d = 1'b0;
      pulse_d = 1'b0;
    end

    cnt_d = (state_d == state_q) ? cnt_q + 32'd1 : 32'd0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= st_idle;
      addr_q   <= CFG_FIRST;
      cnt_q    <= '0;
      start_q  <= 1'b0;
      cs_end_q <= 1'b0;
      pulse_q  <= 1'b0;
      req_q    <= 1'b0;
    end else begin
      state_q  <= state_d;
      addr_q   <= addr_d;
      cnt_q    <= cnt_d;
      start_q  <= start_d;
      cs_end_q <= cs_end_d;
      pulse_q  <= pulse_d;
      req_q    <= req_d;
    end
    time1_q  <= time1_d;
    calib1_q <= calib1_d;
    calib2_q <= calib2_d;
    sample_q <= sample_d;
  end

  // arbiter may latch the sample any cycle before it acks
  a_sample_stable: assert property (@(posedge clk) disable iff (rst)
    sreq.req && !ack |=> $stable(sreq.sample));

endmodule

// ==== verilog/spi_master.sv ====
module spi_master (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       cs_end,
  input  logic [7:0] tx_byte,
  output logic       busy,
  output logic [7:0] rx_byte,
  output logic       sclk,
  output logic       mosi,
  output logic       cs_n,
  input  logic       miso
);

  logic [7:0] tx_sh;    // msb goes out first
  logic [7:0] rx_sh;
  logic [3:0] bit_cnt;  // 8 is the closing cycle
  logic       phase;    // 0 sclk low half, 1 high half
  logic       last;     // this byte ends the frame

  assign mosi = busy & tx_sh[7];  // low between bytes

  // mode 0 with 2 clocks per bit, busy drops 17 clocks after start
  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      bit_cnt <= '0;
      phase   <= 1'b0;
      last    <= 1'b0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        cs_n    <= 1'b0;
        bit_cnt <= '0;
        phase   <= 1'b0;
        last    <= cs_end;
      end
    end else if (bit_cnt == 4'd8) begin
      busy <= 1'b0;
      cs_n <= last;  // stays low for the next byte of the frame
    end else if (!phase) begin
      sclk  <= 1'b1;
      phase <= 1'b1;
    end else begin
      sclk    <= 1'b0;
      phase   <= 1'b0;
      bit_cnt <= bit_cnt + 4'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy)
      tx_sh <= tx_byte;
    else if (busy && phase)
      tx_sh <= {tx_sh[6:0], 1'b0};  // shift on falling sclk
    if (busy && !phase && bit_cnt != 4'd8)
      rx_sh <= {rx_sh[6:0], miso};  // sample on rising sclk
    if (busy && bit_cnt == 4'd8)
      rx_byte <= rx_sh;
  end

endmodule

// ==== verilog/sample_arbiter.sv ====
module sample_arbiter
  import fifo_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  sample_req_t sreq0,
  input  sample_req_t sreq1,
  output logic        ack0,
  output logic        ack1,
  input  logic        full,
  output logic        wr_en,
  output sample_t     wr_data
);

  typedef enum logic [1:0] {gnt_none, gnt_ch0, gnt_ch1} grant_e;

  grant_e grant;
  logic   last_ch1;  // channel 1 won last time
  logic   pick1;     // channel 1 wins if granted now

  assign pick1 = sreq1.req && (!sreq0.req || !last_ch1);

  always_ff @(posedge clk) begin
    if (rst) begin
      grant    <= gnt_none;
      ack0     <= 1'b0;
      ack1     <= 1'b0;
      wr_en    <= 1'b0;
      last_ch1 <= 1'b0;
    end else begin
      wr_en <= 1'b0;  // one write per grant
      case (grant)
        gnt_none: begin
          if (!full && (sreq0.req || sreq1.req)) begin  // full holds ack back
            grant    <= pick1 ? gnt_ch1 : gnt_ch0;
            ack0     <= !pick1;
            ack1     <= pick1;
            wr_en    <= 1'b1;
            last_ch1 <= pick1;
          end
        end
        gnt_ch0: begin
          if (!sreq0.req) begin
            ack0  <= 1'b0;
            grant <= gnt_none;
          end
        end
        gnt_ch1: begin
          if (!sreq1.req) begin
            ack1  <= 1'b0;
            grant <= gnt_none;
          end
        end
        default: grant <= gnt_none;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (grant == gnt_none)
      wr_data <= pick1 ? sreq1.sample : sreq0.sample;
  end

  a_one_ack: assert property (@(posedge clk) disable iff (rst) !(ack0 && ack1));

endmodule

// ==== verilog/sample_fifo.sv ====
module sample_fifo
  import fifo_pkg::*;
#(
  parameter int FIFO_DEPTH = 16  // power of two
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    wr_en,
  input  logic    rd_en,
  input  sample_t wr_data,
  output sample_t rd_data,
  output logic    empty,
  output logic    full
);

  localparam int AW = $clog2(FIFO_DEPTH);

  sample_t     mem [FIFO_DEPTH];
  logic [AW:0] wr_ptr;  // extra msb tells full from empty
  logic [AW:0] rd_ptr;
  logic        do_wr;
  logic        do_rd;

  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign empty   = (wr_ptr == rd_ptr);
  assign full    = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign rd_data = mem[rd_ptr[AW-1:0]];  // head shows without a read

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr[AW-1:0]] <= wr_data;
  end

  // arbiter must hold off while full
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);

endmodule

// ==== verilog/tdc_subsys_top.sv ====
module tdc_subsys_top
  import fifo_pkg::*;
#(
  parameter int SHOT_PERIOD  = 2000,
  parameter int INTB_TIMEOUT = 200,
  parameter int FIFO_DEPTH   = 16
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    soft_reset,
  input  logic    pause,
  input  logic    rd_en,
  input  logic    intb0,
  input  logic    intb1,
  input  logic    miso0,
  input  logic    miso1,
  output logic    sclk0,
  output logic    sclk1,
  output logic    mosi0,
  output logic    mosi1,
  output logic    spi_cs_n0,
  output logic    spi_cs_n1,
  output logic    start_pulse0,
  output logic    start_pulse1,
  output sample_t rd_data,
  output logic    empty,
  output logic    full
);

  logic [1:0]  intb;
  logic [1:0]  miso;
  logic [1:0]  sclk;
  logic [1:0]  mosi;
  logic [1:0]  cs_n;
  logic [1:0]  pulse;
  logic [1:0]  ack;
  sample_req_t sreq [2];
  logic        wr_en;
  sample_t     wr_data;

  assign intb         = {intb1, intb0};
  assign miso         = {miso1, miso0};
  assign sclk0        = sclk[0];
  assign sclk1        = sclk[1];
  assign mosi0        = mosi[0];
  assign mosi1        = mosi[1];
  assign spi_cs_n0    = cs_n[0];
  assign spi_cs_n1    = cs_n[1];
  assign start_pulse0 = pulse[0];
  assign start_pulse1 = pulse[1];

  // one controller and its own spi bus per channel
  for (genvar i = 0; i < 2; i++) begin : g_chan
    logic       spi_start;
    logic       cs_end;
    logic       spi_busy;
    logic [7:0] tx_byte;
    logic [7:0] rx_byte;

    tdc_ctrl #(
      .SHOT_PERIOD  (SHOT_PERIOD),
      .INTB_TIMEOUT (INTB_TIMEOUT),
      .CHAN_ID      (1'(i))
    ) u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .soft_reset  (soft_reset),
      .pause       (pause),
      .intb        (intb[i]),
      .spi_busy    (spi_busy),
      .rx_byte     (rx_byte),
      .spi_start   (spi_start),
      .cs_end      (cs_end),
      .tx_byte     (tx_byte),
      .start_pulse (pulse[i]),
      .sreq        (sreq[i]),
      .ack         (ack[i])
    );

    spi_master u_spi (
      .clk     (clk),
      .rst     (rst),
      .start   (spi_start),
      .cs_end  (cs_end),
      .tx_byte (tx_byte),
      .busy    (spi_busy),
      .rx_byte (rx_byte),
      .sclk    (sclk[i]),
      .mosi    (mosi[i]),
      .cs_n    (cs_n[i]),
      .miso    (miso[i])
    );
  end

  sample_arbiter u_arb (
    .clk     (clk),
    .rst     (rst),
    .sreq0   (sreq[0]),
    .sreq1   (sreq[1]),
    .ack0    (ack[0]),
    .ack1    (ack[1]),
    .full    (full),
    .wr_en   (wr_en),
    .wr_data (wr_data)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .empty   (empty),
    .full    (full)
  );

endmodule

// ==== test/tdc_chip_model.sv ====
module tdc_chip_model (
  input  logic        clk,
  input  logic        sclk,
  input  logic        mosi,
  input  logic        cs_n,
  input  logic        start_pulse,
  input  logic [15:0] time1,       // programmed results
  input  logic [15:0] calib1,
  input  logic [15:0] calib2,
  input  int          intb_delay,  // clocks after start pulse, negative means never
  input  logic        seq_clr,     // restart the time1 sequence offset
  output logic        miso,
  output logic        intb
);

  logic [7:0]  regs [128];      // register file, written over spi
  logic [7:0]  shreg;           // mosi shifter
  logic [7:0]  cmd;             // first byte of the frame
  logic [23:0] rd_word;         // three bytes returned after a read command
  int          nbits    = 0;    // sclk edges since cs_n fell
  int          wr_cnt   = 0;    // register writes seen
  int          trig_cnt = 0;    // start-measurement writes seen
  int          trig_seen = 0;
  int          t1_reads = 0;    // time1 reads, added to time1 as a sequence tag
  int          t1_base  = 0;
  int          dly_cnt  = 0;
  logic        armed    = 1'b0;
  logic        pulse_d  = 1'b0;
  logic        miso_q   = 1'b0;
  logic        intb_q   = 1'b1;  // idle high

  assign miso = miso_q;
  assign intb = intb_q;

  initial begin
    for (int i = 0; i < 128; i++)
      regs[i] = 8'h80 | 8'(i);  // fill differs from every config value
  end

  // frame decode, cs_n high clears the bit count
  always @(posedge sclk or posedge cs_n) begin
    if (cs_n) begin
      nbits = 0;
    end else begin
      shreg = {shreg[6:0], mosi};
      nbits = nbits + 1;
      if (nbits == 8) begin
        cmd = shreg;
        case (cmd)
          8'h10: begin  // time1, tagged with the read count
            rd_word  = {8'ha5, time1 + 16'(t1_reads - t1_base)};
            t1_reads = t1_reads + 1;
          end
          8'h1b:   rd_word = {8'h5a, calib1};  // upper byte is dropped by the reader
          8'h1c:   rd_word = {8'h3c, calib2};
          default: rd_word = 24'h000000;
        endcase
      end else if (nbits == 16 && cmd[7]) begin
        regs[cmd[6:0]] = shreg;
        wr_cnt = wr_cnt + 1;
        if (cmd[6:0] == 7'h00 && shreg[0])
          trig_cnt = trig_cnt + 1;  // config1 start bit
      end
    end
  end

  // miso changes on falling sclk, ready before the next rise
  always @(negedge sclk) begin
    if (nbits >= 8 && nbits < 32 && !cmd[7])
      miso_q = rd_word[31 - nbits];
    else
      miso_q = 1'b0;
  end

  always @(posedge clk) begin
    pulse_d <= start_pulse;
    if (seq_clr)
      t1_base <= t1_reads;
    if (trig_cnt != trig_seen) begin
      trig_seen <= trig_cnt;
      intb_q    <= 1'b1;  // new measurement clears the interrupt
      armed     <= 1'b0;
    end else if (start_pulse && !pulse_d && intb_delay >= 0) begin
      armed   <= 1'b1;
      dly_cnt <= intb_delay;
    end else if (armed) begin
      if (dly_cnt == 0) begin
        intb_q <= 1'b0;  // conversion done
        armed  <= 1'b0;
      end else begin
        dly_cnt <= dly_cnt - 1;
      end
    end
  end

endmodule

// ==== test/tdc_subsys_tb.sv ====
module tdc_subsys_tb;
  import fifo_pkg::*;

  localparam int SHOT    = 400;
  localparam int INTB_TO = 80;
  localparam int DEPTH   = 8;

  // config writes as listed in the command rom
  localparam logic [6:0] CFG_ADDR [9] = '{7'h01, 7'h03, 7'h04, 7'h05, 7'h06,
                                          7'h07, 7'h08, 7'h09, 7'h02};
  localparam logic [7:0] CFG_VAL  [9] = '{8'h40, 8'h07, 8'hff, 8'hff, 8'h00,
                                          8'h50, 8'h00, 8'h00, 8'h1f};

  logic        clk = 1'b0;
  logic        rst;
  logic        soft_reset;
  logic        pause;
  logic        rd_en;
  logic        intb0, intb1, miso0, miso1;
  logic        sclk0, sclk1, mosi0, mosi1;
  logic        cs_n0, cs_n1, sp0, sp1;
  sample_t     rd_data;
  logic        empty, full;
  logic [15:0] t1 [2];   // values programmed into the models
  logic [15:0] c1 [2];
  logic [15:0] c2 [2];
  int          dly [2];
  logic        seq_clr;
  int          got [2];  // samples per channel since the last release
  int          seed = 32'h3b8344a1;
  int          errors = 0;
  int          start_errs;
  int          tests = 0;
  int          failed_tests = 0;

  always #20 clk = ~clk;

  tdc_subsys_top #(
    .SHOT_PERIOD (SHOT),
    .INTB_TIMEOUT(INTB_TO),
    .FIFO_DEPTH  (DEPTH)
  ) DUT (
    .clk(clk), .rst(rst), .soft_reset(soft_reset), .pause(pause), .rd_en(rd_en),
    .intb0(intb0), .intb1(intb1), .miso0(miso0), .miso1(miso1),
    .sclk0(sclk0), .sclk1(sclk1), .mosi0(mosi0), .mosi1(mosi1),
    .spi_cs_n0(cs_n0), .spi_cs_n1(cs_n1), .start_pulse0(sp0), .start_pulse1(sp1),
    .rd_data(rd_data), .empty(empty), .full(full)
  );

  tdc_chip_model chip0 (
    .clk(clk), .sclk(sclk0), .mosi(mosi0), .cs_n(cs_n0), .start_pulse(sp0),
    .time1(t1[0]), .calib1(c1[0]), .calib2(c2[0]), .intb_delay(dly[0]),
    .seq_clr(seq_clr), .miso(miso0), .intb(intb0)
  );

  tdc_chip_model chip1 (
    .clk(clk), .sclk(sclk1), .mosi(mosi1), .cs_n(cs_n1), .start_pulse(sp1),
    .time1(t1[1]), .calib1(c1[1]), .calib2(c2[1]), .intb_delay(dly[1]),
    .seq_clr(seq_clr), .miso(miso1), .intb(intb1)
  );

  function automatic logic [7:0] chip_reg(input int ch, input logic [6:0] a);
    return (ch == 0) ? chip0.regs[a] : chip1.regs[a];
  endfunction

  task automatic randomize_values;
    for (int c = 0; c < 2; c++) begin
      t1[c] = 16'($random(seed));
      c1[c] = 16'($random(seed));
      c2[c] = 16'($random(seed));
    end
  endtask

  // k-th sample of a channel carries time1 + k, zero replaced by 1488
  task automatic check_sample(input sample_t s);
    logic [15:0] exp_t1;
    logic [15:0] exp_diff;
    int          c;
    c        = s.chan ? 1 : 0;
    exp_t1   = t1[c] + 16'(got[c]);
    exp_diff = c2[c] - c1[c];
    if (exp_t1 == 16'd0)
      exp_t1 = 16'd1488;
    if (s.time1 !== exp_t1) begin
      $display("[ERROR] %0t rd_data.time1 (chan %0d): got %0d expected %0d",
               $time, c, s.time1, exp_t1);
      errors++;
    end
    if (s.calib_diff !== exp_diff) begin
      $display("[ERROR] %0t rd_data.calib_diff (chan %0d): got %0d expected %0d",
               $time, c, s.calib_diff, exp_diff);
      errors++;
    end
    got[c]++;
  endtask

  // pop until each channel has delivered enough
  task automatic collect(input int n0, input int n1, input int limit);
    int cyc;
    cyc = 0;
    while ((got[0] < n0 || got[1] < n1) && cyc < limit) begin
      @(negedge clk);
      rd_en = !empty;
      if (!empty)
        check_sample(rd_data);
      cyc++;
    end
    @(negedge clk);
    rd_en = 1'b0;
    if (got[0] < n0 || got[1] < n1) begin
      $display("timeout: only %0d and %0d samples arrived, %0d and %0d wanted",
               got[0], got[1], n0, n1);
      errors++;
    end
  endtask

  // pause both channels and empty the fifo until all is quiet
  task automatic freeze_and_drain;
    int quiet;
    int cyc;
    @(negedge clk);
    pause   = 1'b1;
    seq_clr = 1'b1;
    quiet   = 0;
    cyc     = 0;
    while (quiet < 40 && cyc < 3000) begin
      @(negedge clk);
      rd_en = !empty;  // old samples thrown away
      quiet = (cs_n0 && cs_n1 && empty) ? quiet + 1 : 0;
      cyc++;
    end
    @(negedge clk);
    rd_en = 1'b0;
    if (quiet < 40) begin
      $display("timeout: channels did not settle after pause was raised");
      errors++;
    end
  endtask

  task automatic release_pause;
    @(negedge clk);
    got[0]  = 0;
    got[1]  = 0;
    seq_clr = 1'b0;
    pause   = 1'b0;
  endtask

  task automatic test_config;
    int cyc;
    @(negedge clk);
    soft_reset = 1'b1;
    @(negedge clk);
    soft_reset = 1'b0;
    cyc = 0;
    while ((chip0.wr_cnt < 9 || chip1.wr_cnt < 9) && cyc < 2000) begin
      @(negedge clk);
      cyc++;
    end
    if (cyc >= 2000) begin
      $display("timeout: configuration writes did not complete");
      errors++;
    end
    for (int ch = 0; ch < 2; ch++) begin
      for (int i = 0; i < 9; i++) begin
        if (chip_reg(ch, CFG_ADDR[i]) !== CFG_VAL[i]) begin
          $display("[ERROR] %0t chip%0d.regs[%02h]: got %02h expected %02h", $time, ch,
                   CFG_ADDR[i], chip_reg(ch, CFG_ADDR[i]), CFG_VAL[i]);
          errors++;
        end
      end
    end
  endtask

  task automatic test_measure;
    freeze_and_drain();
    randomize_values();
    release_pause();
    collect(3, 3, 8000);
  endtask

  task automatic test_zero_sub;
    freeze_and_drain();
    randomize_values();
    t1[0] = 16'h0000;  // first sample is zero
    t1[1] = 16'hffff;  // second sample wraps to zero
    release_pause();
    collect(2, 2, 6000);
  endtask

  task automatic test_timeout;
    freeze_and_drain();
    randomize_values();
    dly[1] = -1;  // chip 1 never finishes
    release_pause();
    collect(3, 0, 8000);  // spans more than three shot periods
    if (got[1] != 0) begin
      $display("channel 1 delivered %0d samples although its intb never fell", got[1]);
      errors++;
    end
  endtask

  task automatic test_pause;
    logic cs_fell;
    logic sample_seen;
    freeze_and_drain();
    cs_fell     = 1'b0;
    sample_seen = 1'b0;
    for (int i = 0; i < 3 * SHOT; i++) begin
      @(negedge clk);
      if (!cs_n0 || !cs_n1)
        cs_fell = 1'b1;
      if (!empty)
        sample_seen = 1'b1;
    end
    if (cs_fell) begin
      $display("an spi chip select fell while pause was high");
      errors++;
    end
    if (sample_seen) begin
      $display("a sample reached the fifo while pause was high");
      errors++;
    end
    dly[1] = 35;
    randomize_values();
    release_pause();
    collect(2, 2, 6000);
  endtask

  task automatic test_backpressure;
    int cyc;
    freeze_and_drain();
    randomize_values();
    release_pause();
    cyc = 0;
    while (!full && cyc < 20000) begin  // rd_en stays low
      @(negedge clk);
      cyc++;
    end
    if (!full) begin
      $display("timeout: fifo never became full");
      errors++;
    end
    repeat (3 * SHOT) @(negedge clk);  // both controllers end up stalled
    collect(6, 6, 20000);
  endtask

  task automatic report(input string name);
    tests++;
    if (errors > start_errs) begin
      failed_tests++;
      $display("test %s: FAIL, %0d errors", name, errors - start_errs);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    rst        = 1'b1;
    soft_reset = 1'b0;
    pause      = 1'b0;
    rd_en      = 1'b0;
    seq_clr    = 1'b0;
    t1[0]      = 16'd100;
    t1[1]      = 16'd200;
    c1[0]      = 16'd10;
    c1[1]      = 16'd20;
    c2[0]      = 16'd50;
    c2[1]      = 16'd90;
    dly[0]     = 20;
    dly[1]     = 35;
    got[0]     = 0;
    got[1]     = 0;
    repeat (3) @(negedge clk);
    rst = 1'b0;

    start_errs = errors;
    test_config();
    report("config");
    start_errs = errors;
    test_measure();
    report("measure");
    start_errs = errors;
    test_zero_sub();
    report("zero_sub");
    start_errs = errors;
    test_timeout();
    report("intb_timeout");
    start_errs = errors;
    test_pause();
    report("pause");
    start_errs = errors;
    test_backpressure();
    report("backpressure");

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// ==== vlog.f ====
common/tdc_pkg.sv
common/fifo_pkg.sv
tdc_ctrl/tdc_cmd_rom.sv
tdc_ctrl/tdc_ctrl.sv
verilog/spi_master.sv
verilog/sample_arbiter.sv
verilog/sample_fifo.sv
verilog/tdc_subsys_top.sv
test/tdc_chip_model.sv
test/tdc_subsys_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, result taken from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tdc_subsys_tb \
  -o tdc_sim > build.log 2>&1 \
  && ./obj_dir/tdc_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
